// File: rtl/l2d_pkg.sv
package l2d_pkg;

  // line geometry
  localparam int BANK_COUNT = 8;
  localparam int WORD_W     = 32;
  localparam int BYTE_COUNT = 4;

  // set addressing
  localparam int INDEX_W    = 8;
  localparam int SET_COUNT  = 256; // 2**INDEX_W

  // read lines waiting for the response port
  localparam int RESP_DEPTH = 4;

  typedef logic [WORD_W-1:0]              word_t;
  typedef logic [INDEX_W-1:0]             index_t;
  typedef logic [$clog2(BANK_COUNT)-1:0]  bank_sel_t;
  typedef logic [BYTE_COUNT-1:0]          ben_t;

  // bank 0 sits in the low word
  typedef word_t [BANK_COUNT-1:0] line_t;

  // request as it arrives on the valid/ready port
  typedef struct packed {
    logic      write;
    index_t    index;
    bank_sel_t begin_bank;
    bank_sel_t end_bank;
    ben_t      begin_ben;
    ben_t      end_ben;
    line_t     data;       // word b goes to bank b
  } l2d_req_t;

  // command broadcast to every bank
  typedef struct packed {
    index_t                  index;
    logic [BANK_COUNT-1:0]   wen;
    ben_t [BANK_COUNT-1:0]   ben;
    line_t                   data;
  } l2d_cmd_t;

endpackage

// File: rtl/l2d_req_decode.sv
module l2d_req_decode (
  input  logic                clk,
  input  logic                rst,
  input  logic                req_valid,
  input  l2d_pkg::l2d_req_t   req,
  input  logic                room,
  output logic                req_ready,
  output l2d_pkg::l2d_cmd_t   cmd,
  output logic                cmd_read
);

  logic                                   accept;
  logic [l2d_pkg::BANK_COUNT-1:0]         wen_next;
  l2d_pkg::ben_t [l2d_pkg::BANK_COUNT-1:0] ben_next;

  // ready only while the response queue can take one more read
  assign req_ready = room;
  assign accept    = req_valid && room;

  // begin/end range to per-bank write enables and byte masks
  always_comb begin
    l2d_pkg::bank_sel_t sel;
    logic               is_begin;
    logic               is_end;

    for (int b = 0; b < l2d_pkg::BANK_COUNT; b++) begin
      sel      = l2d_pkg::bank_sel_t'(b);
      is_begin = (sel == req.begin_bank);
      is_end   = (sel == req.end_bank);

      // empty range when begin is past end
      wen_next[b] = req.write &&
                    (sel >= req.begin_bank) &&
                    (sel <= req.end_bank);

      if (is_begin && is_end) begin
        ben_next[b] = req.begin_ben & req.end_ben; // single-bank write
      end else if (is_begin) begin
        ben_next[b] = req.begin_ben;
      end else if (is_end) begin
        ben_next[b] = req.end_ben;
      end else begin
        ben_next[b] = '1; // inner banks take the whole word
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd.wen  <= '0;
      cmd_read <= 1'b0;
    end else begin
      cmd.wen  <= accept ? wen_next : '0;
      cmd_read <= accept && !req.write;
    end

    // payload follows the accepted request
    if (accept) begin
      cmd.index <= req.index;
      cmd.ben   <= ben_next;
      cmd.data  <= req.data;
    end
  end

endmodule

// File: rtl/l2d_bank.sv
module l2d_bank (
  input  logic            clk,
  input  logic            rst,
  input  l2d_pkg::index_t index,
  input  logic            wen,
  input  l2d_pkg::ben_t   ben,
  input  l2d_pkg::word_t  data,
  output l2d_pkg::word_t  word
);

  l2d_pkg::word_t  ram [l2d_pkg::SET_COUNT];

  l2d_pkg::index_t index_r;  // read and write address
  logic            wen_r;
  l2d_pkg::ben_t   ben_r;
  l2d_pkg::word_t  data_r;

  l2d_pkg::word_t  old_word;
  l2d_pkg::word_t  merged;

  assign old_word = ram[index_r];

  // byte merge of the new data into the old word
  always_comb begin
    merged = old_word;
    for (int i = 0; i < l2d_pkg::BYTE_COUNT; i++) begin
      if (ben_r[i]) begin
        merged[8*i +: 8] = data_r[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wen_r <= 1'b0;
    end else begin
      wen_r <= wen;
    end
    index_r <= index;
    ben_r   <= ben;
    data_r  <= data;
  end

  // write back lands before the next request reads the same set
  always_ff @(posedge clk) begin
    if (wen_r) begin
      ram[index_r] <= merged;
    end
    word <= old_word;
  end

endmodule

// File: rtl/l2d_resp_queue.sv
module l2d_resp_queue (
  input  logic           clk,
  input  logic           rst,
  input  logic           cmd_read,
  input  l2d_pkg::line_t bank_words,
  input  logic           rsp_ready,
  output logic           room,
  output logic           rsp_valid,
  output l2d_pkg::line_t rsp_data
);

  l2d_pkg::line_t fifo [l2d_pkg::RESP_DEPTH];

  logic [$clog2(l2d_pkg::RESP_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(l2d_pkg::RESP_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(l2d_pkg::RESP_DEPTH+1)-1:0] count;
  logic [$clog2(l2d_pkg::RESP_DEPTH+1)-1:0] pending;

  logic read_d1; // bank address registered
  logic read_d2; // bank words valid
  logic push;
  logic pop;

  assign push = read_d2;
  assign pop  = rsp_valid && rsp_ready;

  assign rsp_valid = (count != '0);
  assign rsp_data  = fifo[rd_ptr];

  // queued lines plus reads still in the pipe
  assign pending = count + cmd_read + read_d1 + read_d2;
  assign room    = (pending < l2d_pkg::RESP_DEPTH);

  always_ff @(posedge clk) begin
    if (rst) begin
      read_d1 <= 1'b0;
      read_d2 <= 1'b0;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
    end else begin
      read_d1 <= cmd_read;
      read_d2 <= read_d1;
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // never full on a push, room keeps a slot for every read in flight
  always_ff @(posedge clk) begin
    if (push) begin
      fifo[wr_ptr] <= bank_words;
    end
  end

endmodule

// File: rtl/l2d_data_array.sv
module l2d_data_array (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid,
  output logic              req_ready,
  input  l2d_pkg::l2d_req_t req,
  output logic              rsp_valid,
  input  logic              rsp_ready,
  output l2d_pkg::line_t    rsp_data
);

  l2d_pkg::l2d_cmd_t cmd;
  logic              cmd_read;
  logic              room;
  l2d_pkg::line_t    bank_words;

  l2d_req_decode u_decode (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .room      (room),
    .req_ready (req_ready),
    .cmd       (cmd),
    .cmd_read  (cmd_read)
  );

  // one bank per word of the line
  for (genvar b = 0; b < l2d_pkg::BANK_COUNT; b++) begin : g_bank
    l2d_bank u_bank (
      .clk   (clk),
      .rst   (rst),
      .index (cmd.index),
      .wen   (cmd.wen[b]),
      .ben   (cmd.ben[b]),
      .data  (cmd.data[b]),
      .word  (bank_words[b])
    );
  end

  l2d_resp_queue u_queue (
    .clk        (clk),
    .rst        (rst),
    .cmd_read   (cmd_read),
    .bank_words (bank_words),
    .rsp_ready  (rsp_ready),
    .room       (room),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data)
  );

endmodule

// File: bench/clk_gen.sv
module clk_gen (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period
  end

  // reset spans the first 8 rising edges
  initial begin
    rst = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

// File: bench/l2d_props.sv
module l2d_resp_props (
  input logic                                     clk,
  input logic                                     rst,
  input logic                                     rsp_valid,
  input logic                                     rsp_ready,
  input logic                                     room,
  input logic                                     push,
  input l2d_pkg::line_t                           rsp_data,
  input logic [$clog2(l2d_pkg::RESP_DEPTH+1)-1:0] count
);
  timeunit 1ns;
  timeprecision 1ps;

  int prop_fails = 0;

  // stalled response keeps its line
  a_hold: assert property (@(posedge clk) disable iff (rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
    else begin
      $error("response changed while stalled");
      prop_fails++;
    end

  a_reset: assert property (@(posedge clk) rst |=> !rsp_valid)
    else begin
      $error("rsp_valid high right after reset");
      prop_fails++;
    end

  // a full queue takes no new request and no new line
  a_full: assert property (@(posedge clk) disable iff (rst)
    (count == l2d_pkg::RESP_DEPTH) |-> !room && !push)
    else begin
      $error("room high or a line pushed with the queue full");
      prop_fails++;
    end

endmodule

bind l2d_resp_queue l2d_resp_props u_props (
  .clk       (clk),
  .rst       (rst),
  .rsp_valid (rsp_valid),
  .rsp_ready (rsp_ready),
  .room      (room),
  .push      (push),
  .rsp_data  (rsp_data),
  .count     (count)
);

// File: bench/l2d_tb.sv
module l2d_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int STIM_COUNT   = 18;
  localparam int RESET_CYCLES = 8;
  localparam int CYCLE_LIMIT  = 40 * STIM_COUNT + RESET_CYCLES;
  localparam int READ_LATENCY = 3;

  typedef struct packed {
    l2d_pkg::l2d_req_t req;
    logic              hold; // keep rsp_ready low
  } stim_t;

  typedef struct {
    l2d_pkg::line_t line;
    int             cycle;
    logic           idle;
  } exp_t;

  logic              clk;
  logic              rst;
  logic              req_valid = 1'b0;
  logic              req_ready;
  l2d_pkg::l2d_req_t req = '0;
  logic              rsp_valid;
  logic              rsp_ready;
  l2d_pkg::line_t    rsp_data;

  logic              hold_rsp = 1'b0;
  logic              stall = 1'b0;
  logic [31:0]       lfsr = 32'h5c251eb4;

  stim_t             stim [STIM_COUNT];
  l2d_pkg::line_t    shadow [l2d_pkg::SET_COUNT];
  exp_t              exp_q [$];
  int                outstanding = 0;
  int                sample_cycle = 0;
  logic              prev_valid = 1'b0;
  int                data_errors = 0;
  int                handshake_errors = 0;
  int                timeout_errors = 0;

  assign rsp_ready = !hold_rsp && !stall;

  clk_gen u_clk (
    .clk (clk),
    .rst (rst)
  );

  l2d_data_array u_dut (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data)
  );

  function automatic logic [31:0] lfsr_step(logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h80200003;
    end else begin
      return state >> 1;
    end
  endfunction

  function automatic l2d_pkg::line_t fill_line(int tag);
    l2d_pkg::line_t line;
    for (int b = 0; b < l2d_pkg::BANK_COUNT; b++) begin
      line[b] = {8'(tag), 8'(b), 8'(tag ^ 8'h5a), 8'(16 * b + tag)};
    end
    return line;
  endfunction

  // bytes a write touches in bank b, zero outside the range
  function automatic l2d_pkg::ben_t lane_mask(int b, l2d_pkg::l2d_req_t r);
    l2d_pkg::ben_t mask;
    mask = '1;
    if (b < int'(r.begin_bank) || b > int'(r.end_bank)) begin
      mask = '0;
    end else begin
      if (b == int'(r.begin_bank)) begin
        mask = mask & r.begin_ben;
      end
      if (b == int'(r.end_bank)) begin
        mask = mask & r.end_ben;
      end
    end
    return mask;
  endfunction

  function automatic l2d_pkg::line_t merge_line(l2d_pkg::line_t old, l2d_pkg::l2d_req_t r);
    l2d_pkg::line_t result;
    l2d_pkg::ben_t  mask;
    result = old;
    for (int b = 0; b < l2d_pkg::BANK_COUNT; b++) begin
      mask = lane_mask(b, r);
      for (int k = 0; k < l2d_pkg::BYTE_COUNT; k++) begin
        if (mask[k]) begin
          result[b][8*k +: 8] = r.data[b][8*k +: 8];
        end
      end
    end
    return result;
  endfunction

  function automatic stim_t make_entry(logic write, l2d_pkg::index_t index,
                                       l2d_pkg::bank_sel_t first, l2d_pkg::bank_sel_t last,
                                       l2d_pkg::ben_t first_ben, l2d_pkg::ben_t last_ben,
                                       int tag, logic hold);
    stim_t s;
    s.req.write      = write;
    s.req.index      = index;
    s.req.begin_bank = first;
    s.req.end_bank   = last;
    s.req.begin_ben  = first_ben;
    s.req.end_ben    = last_ben;
    s.req.data       = write ? fill_line(tag) : '0;
    s.hold           = hold;
    return s;
  endfunction

  task automatic load_table();
    stim[0]  = make_entry(1'b1, 8'h10, 0, 7, 4'hf, 4'hf, 1, 1'b0);
    stim[1]  = make_entry(1'b0, 8'h10, 0, 0, 4'h0, 4'h0, 0, 1'b0);
    stim[2]  = make_entry(1'b1, 8'h10, 2, 5, 4'b1100, 4'b0011, 2, 1'b0);
    stim[3]  = make_entry(1'b0, 8'h10, 0, 0, 4'h0, 4'h0, 0, 1'b0);
    stim[4]  = make_entry(1'b1, 8'h20, 0, 7, 4'hf, 4'hf, 3, 1'b0);
    stim[5]  = make_entry(1'b1, 8'h20, 3, 3, 4'b1110, 4'b0111, 4, 1'b0); // single bank
    stim[6]  = make_entry(1'b1, 8'h20, 6, 1, 4'hf, 4'hf, 5, 1'b0);       // empty range
    stim[7]  = make_entry(1'b0, 8'h20, 0, 0, 4'h0, 4'h0, 0, 1'b0);
    stim[8]  = make_entry(1'b1, 8'h30, 0, 7, 4'hf, 4'hf, 6, 1'b0);
    stim[9]  = make_entry(1'b1, 8'h30, 1, 6, 4'b0001, 4'b1000, 7, 1'b0);
    stim[10] = make_entry(1'b1, 8'h30, 4, 7, 4'b1010, 4'b0101, 8, 1'b0);
    stim[11] = make_entry(1'b0, 8'h30, 0, 0, 4'h0, 4'h0, 0, 1'b0);
    // four reads against a stalled response port
    stim[12] = make_entry(1'b0, 8'h10, 0, 0, 4'h0, 4'h0, 0, 1'b1);
    stim[13] = make_entry(1'b0, 8'h20, 0, 0, 4'h0, 4'h0, 0, 1'b1);
    stim[14] = make_entry(1'b0, 8'h30, 0, 0, 4'h0, 4'h0, 0, 1'b1);
    stim[15] = make_entry(1'b0, 8'h10, 0, 0, 4'h0, 4'h0, 0, 1'b1);
    stim[16] = make_entry(1'b0, 8'h20, 0, 0, 4'h0, 4'h0, 0, 1'b0);
    stim[17] = make_entry(1'b0, 8'h30, 0, 0, 4'h0, 4'h0, 0, 1'b0);
  endtask

  task automatic finish_run();
    int prop_fails;
    prop_fails = u_dut.u_queue.u_props.prop_fails;
    $display("errors: data %0d, handshake %0d, timeout %0d, assertion %0d",
             data_errors, handshake_errors, timeout_errors, prop_fails);
    if (data_errors + handshake_errors + timeout_errors + prop_fails == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  // response checker, sees pre-edge values at each rising edge
  always @(posedge clk) begin
    exp_t head;
    exp_t entry;
    sample_cycle++;
    if (!rst) begin
      assert (req_ready === (outstanding < l2d_pkg::RESP_DEPTH)) else begin
        $display("Fail req_ready got %h expected %h", req_ready,
                 outstanding < l2d_pkg::RESP_DEPTH);
        handshake_errors++;
      end
      // rise happened on the previous edge
      if (rsp_valid && !prev_valid && exp_q.size() != 0 && exp_q[0].idle) begin
        assert (sample_cycle - 1 - exp_q[0].cycle == READ_LATENCY) else begin
          $display("Fail rsp_valid latency got %h expected %h",
                   sample_cycle - 1 - exp_q[0].cycle, READ_LATENCY);
          handshake_errors++;
        end
      end
      if (rsp_valid && rsp_ready) begin
        if (exp_q.size() == 0) begin
          $display("a response arrived with no read outstanding");
          handshake_errors++;
        end else begin
          head = exp_q.pop_front();
          outstanding--;
          assert (rsp_data === head.line) else begin
            $display("Fail rsp_data got %h expected %h", rsp_data, head.line);
            data_errors++;
          end
        end
      end
      if (req_valid && req_ready) begin
        if (req.write) begin
          shadow[req.index] = merge_line(shadow[req.index], req);
        end else begin
          entry.line  = shadow[req.index];
          entry.cycle = sample_cycle;
          entry.idle  = (outstanding == 0);
          exp_q.push_back(entry);
          outstanding++;
        end
      end
      prev_valid = rsp_valid;
    end
    #1;
    lfsr  = lfsr_step(lfsr);
    stall = lfsr[0]; // one bit per cycle
  end

  initial begin
    for (int n = 0; n < CYCLE_LIMIT; n++) begin
      @(posedge clk);
    end
    $display("the run did not finish within %0d cycles", CYCLE_LIMIT);
    timeout_errors++;
    finish_run();
  end

  initial begin
    load_table();
    wait (rst === 1'b0);
    @(posedge clk);
    assert (req_ready === 1'b1) else begin
      $display("Fail req_ready got %h expected 1 after reset", req_ready);
      handshake_errors++;
    end
    assert (rsp_valid === 1'b0) else begin
      $display("Fail rsp_valid got %h expected 0 after reset", rsp_valid);
      handshake_errors++;
    end
    #1;
    for (int i = 0; i < STIM_COUNT; i++) begin
      if (stim[i].hold && !hold_rsp) begin
        // stalled reads start from an empty response queue
        while (exp_q.size() != 0) begin
          @(negedge clk);
        end
        @(posedge clk);
        #1;
      end
      if (hold_rsp && !stim[i].hold) begin
        // held lines settle into the queue first
        repeat (4) @(posedge clk);
        assert (!req_ready) else begin
          $display("req_ready stayed high with the response queue full");
          handshake_errors++;
        end
        #1;
      end
      hold_rsp  = stim[i].hold;
      req       = stim[i].req;
      req_valid = 1'b1;
      do begin
        @(posedge clk);
      end while (!req_ready);
      #1;
      req_valid = 1'b0;
    end
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(posedge clk);
    finish_run();
  end

endmodule

// File: src.f
rtl/l2d_pkg.sv
rtl/l2d_req_decode.sv
rtl/l2d_bank.sv
rtl/l2d_resp_queue.sv
rtl/l2d_data_array.sv
bench/clk_gen.sv
bench/l2d_props.sv
bench/l2d_tb.sv
